// File: src.f
common/ex_sizes_pkg.sv
common/ex_isa_pkg.sv
common/ex_op_if.sv
source/ex_op_queue.sv
source/ex_issue.sv
ex_alu/ex_alu.sv
source/ex_stage.sv
test/tb_ex_stage.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --main -Mdir build
TOP       ?= tb_ex_stage
FILELIST  ?= src.f
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench, pass when the log holds the pass line"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./build/V$(TOP) | tee $(LOG)
	grep -q "PASS: all tests" $(LOG)

clean:
	rm -rf build $(LOG)

// File: test/tb_ex_stage.sv
module tb_ex_stage import ex_sizes_pkg::*, ex_isa_pkg::*; ();

    localparam int FIFO_DEPTH = 4;
    localparam logic [5:0] LEGAL_OPS [18] = '{6'h00, 6'h01, 6'h02, 6'h03, 6'h04, 6'h05, 6'h06,
        6'h07, 6'h09, 6'h0A, 6'h0B, 6'h0C, 6'h0D, 6'h0E, 6'h10, 6'h11, 6'h12, 6'h13};

    logic   iw_clk;
    logic   iw_rst;
    logic   in_req;
    logic   in_ack;
    opc_e   in_opc;
    cc_e    in_cc;
    data_t  in_pc;
    data_t  in_src;
    data_t  in_tgt;
    imm_t   in_imm;
    logic   out_req;
    logic   out_ack;
    data_t  out_result;
    flags_t out_flags;
    logic   out_branch_taken;
    data_t  out_branch_pc;

    logic [31:0] tx_state;
    logic [31:0] rx_state;
    logic [3:0]  m_flags;  // Model flags as {z, n, c, v}
    logic [31:0] exp_res [$];
    logic [3:0]  exp_flags [$];
    logic        exp_taken [$];
    logic [31:0] exp_bpc [$];
    int          n_fail;
    int          n_other;
    bit          stall;

    ex_stage #(.FIFO_DEPTH (FIFO_DEPTH)) u_dut (.*);

    initial begin
        iw_clk = 1'b0;
        forever #5 iw_clk = ~iw_clk;
    end

    // ####################
    // Random numbers and checks
    // ####################

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] tx_bits(input int n);
        logic [31:0] r;
        r = '0;
        repeat (n) begin
            tx_state = lfsr_step(tx_state);
            r = {r[30:0], tx_state[0]};
        end
        return r;
    endfunction

    function automatic logic [31:0] rx_bits(input int n);
        logic [31:0] r;
        r = '0;
        repeat (n) begin
            rx_state = lfsr_step(rx_state);
            r = {r[30:0], rx_state[0]};
        end
        return r;
    endfunction

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            n_fail++;
            $display("Fail %s: got %h, expected %h", name, got, exp);
        end
    endtask

    function automatic logic out_of_range(input longint s);
        return (s > 64'sd2147483647) || (s < -64'sd2147483648);
    endfunction

    function automatic logic cond_met(input logic [3:0] cc, input logic [3:0] f);
        logic z, n, c, v;
        {z, n, c, v} = f;
        case (cc)
            4'h0:    return 1'b1;
            4'h1:    return z;
            4'h2:    return !z;
            4'h3:    return n ^ v;
            4'h4:    return !z && !(n ^ v);
            4'h5:    return !(n ^ v);
            4'h6:    return z || (n ^ v);
            4'h7:    return c;
            4'h8:    return !c && !z;
            4'h9:    return c || z;
            4'hA:    return !c;
            default: return 1'b0;
        endcase
    endfunction

    // ####################
    // Reference model
    // ####################

    task automatic model_op(input logic [5:0] opc, input logic [3:0] cc, input logic [31:0] pc,
                            input logic [31:0] src, input logic [31:0] tgt, input logic [11:0] imm);
        logic [31:0] a, b, r, d;
        logic        z, n, c, v, cy, big, taken;
        longint      sa, sb;
        {z, n, c, v} = m_flags;
        a = src;
        b = tgt;
        r = '0;
        taken = 1'b0;
        if (opc == 6'h10 || opc == 6'h11) a = {20'h0, imm};
        if (opc == 6'h12 || opc == 6'h13) a = {{20{imm[11]}}, imm};
        sa = longint'($signed(a));
        sb = longint'($signed(b));
        big = (a > 32'd31);
        d = b - a;
        case (opc)
            6'h00, 6'h10: r = a;
            6'h01, 6'h11: begin
                {cy, r} = {1'b0, a} + {1'b0, b};
                c = cy;
            end
            6'h0A, 6'h12: begin
                r = a + b;
                n = r[31];
                v = out_of_range(sa + sb);
            end
            6'h02: begin
                r = d;
                c = (b < a);
            end
            6'h0B: begin
                r = d;
                n = r[31];
                v = out_of_range(sb - sa);
            end
            6'h03: r = a & b;
            6'h04: r = a | b;
            6'h05: r = a ^ b;
            6'h06: r = big ? 32'h0 : b << a[4:0];
            6'h07: r = big ? 32'h0 : b >> a[4:0];
            6'h0C: r = big ? 32'h0 : 32'($signed(b) >>> a[4:0]);
            6'h09: c = (b < a);
            6'h0D: begin
                n = d[31];
                v = out_of_range(sb - sa);
            end
            6'h0E, 6'h13: taken = cond_met(cc, m_flags);
            default: {z, n, c, v} = 4'h0;  // Illegal opcode
        endcase
        if (opc inside {6'h00, 6'h01, 6'h02, 6'h03, 6'h04, 6'h05, 6'h06, 6'h07, 6'h0A, 6'h0B,
                        6'h0C, 6'h10, 6'h11, 6'h12}) z = (r == 32'h0);
        if (opc inside {6'h09, 6'h0D}) z = (a == b);
        if (opc inside {6'h06, 6'h07, 6'h0C}) v = big;
        if (opc == 6'h0C) n = r[31];
        exp_res.push_back(r);
        exp_flags.push_back({z, n, c, v});
        exp_taken.push_back(taken);
        exp_bpc.push_back(taken ? pc + a : 32'h0);
        m_flags = {z, n, c, v};
    endtask

    // ####################
    // Input side
    // ####################

    task automatic release_req();
        int n;
        in_req = 1'b0;
        n = 0;
        while (in_ack && n < 20) begin
            @(negedge iw_clk);
            n++;
        end
        if (in_ack) begin
            n_other++;
            $display("Error: in_ack did not fall after in_req dropped");
        end
    endtask

    task automatic send_instr(input logic [5:0] opc, input logic [3:0] cc, input logic [31:0] src,
                              input logic [31:0] tgt, input int max_wait, output bit acked);
        logic [31:0] pc;
        logic [11:0] imm;
        int          n;
        pc  = tx_bits(32);
        imm = 12'(tx_bits(12));
        model_op(opc, cc, pc, src, tgt, imm);
        repeat (tx_bits(3) % 6) @(negedge iw_clk);
        in_opc = opc_e'(opc);
        in_cc  = cc_e'(cc);
        in_pc  = pc;
        in_src = src;
        in_tgt = tgt;
        in_imm = imm;
        in_req = 1'b1;
        n = 0;
        while (!in_ack && n < max_wait) begin
            @(negedge iw_clk);
            n++;
        end
        acked = in_ack;
        if (acked) release_req();  // Otherwise in_req stays high for the caller
    endtask

    task automatic expect_ack(input bit acked);
        if (!acked) begin
            n_other++;
            $display("Error: in_ack did not rise for an instruction");
        end
    endtask

    task automatic send_random(input int max_wait, output bit acked);
        logic [5:0]  opc;
        logic [31:0] src;
        logic [31:0] tgt;
        if (tx_bits(4) == 0) begin
            case (tx_bits(2))
                32'd0:   opc = 6'h08;
                32'd1:   opc = 6'h0F;
                default: opc = 6'h14 + 6'(tx_bits(5));
            endcase
        end else begin
            opc = LEGAL_OPS[5'(tx_bits(5) % 18)];
        end
        src = (opc inside {6'h06, 6'h07, 6'h0C} && tx_bits(2) != 0) ? tx_bits(5) : tx_bits(32);
        tgt = (tx_bits(3) == 0) ? src : tx_bits(32);  // Equal operands now and then
        send_instr(opc, 4'(tx_bits(4)), src, tgt, max_wait, acked);
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while ((exp_res.size() != 0 || out_req || out_ack) && n < 3000) begin
            @(negedge iw_clk);
            n++;
        end
        if (exp_res.size() != 0) begin
            n_other++;
            $display("Error: %0d results never came out", exp_res.size());
        end
    endtask

    // ####################
    // Output side
    // ####################

    initial begin : receiver
        int idle;
        int n;
        idle = 0;
        rx_state = 32'h8279_030e;
        forever begin
            @(negedge iw_clk);
            if (!out_req) begin
                idle = (exp_res.size() != 0) ? idle + 1 : 0;
                if (idle == 400) begin
                    n_other++;
                    $display("Error: no result appeared for a pending instruction");
                end
            end else begin
                idle = 0;
                if (exp_res.size() == 0) begin
                    n_other++;
                    $display("Error: out_req rose with no instruction pending");
                end else begin
                    check_val("out_result", out_result, exp_res.pop_front());
                    check_val("out_flags", 32'(out_flags), 32'(exp_flags.pop_front()));
                    check_val("out_branch_taken", 32'(out_branch_taken),
                              32'(exp_taken.pop_front()));
                    check_val("out_branch_pc", out_branch_pc, exp_bpc.pop_front());
                end
                repeat (rx_bits(3) % 6) @(negedge iw_clk);
                n = 0;
                while (stall && n < 500) begin
                    @(negedge iw_clk);
                    n++;
                end
                if (stall) begin
                    n_other++;
                    $display("Error: out_ack stayed withheld far too long");
                end
                out_ack = 1'b1;
                n = 0;
                while (out_req && n < 20) begin
                    @(negedge iw_clk);
                    n++;
                end
                if (out_req) begin
                    n_other++;
                    $display("Error: out_req did not fall after out_ack rose");
                end
                out_ack = 1'b0;
            end
        end
    end

    // ####################
    // Test sequence
    // ####################

    initial begin
        bit acked;
        int n_acked;
        int n;
        tx_state = 32'h8279_030e;
        m_flags  = 4'h0;
        n_fail   = 0;
        n_other  = 0;
        stall    = 1'b0;
        iw_rst   = 1'b1;
        in_req   = 1'b0;
        in_opc   = OPC_MOVU;
        in_cc    = CC_RA;
        in_pc    = '0;
        in_src   = '0;
        in_tgt   = '0;
        in_imm   = '0;
        out_ack  = 1'b0;
        repeat (3) @(posedge iw_clk);
        @(negedge iw_clk);
        iw_rst = 1'b0;

        check_val("in_ack", 32'(in_ack), 32'h0);
        repeat (10) begin
            @(negedge iw_clk);
            check_val("out_req", 32'(out_req), 32'h0);
        end

        repeat (300) begin
            send_random(50, acked);
            expect_ack(acked);
        end

        // C from the compare must survive MOV and AND to steer the branches
        send_instr(6'h09, 4'h0, 32'd5, 32'd3, 50, acked);
        expect_ack(acked);
        send_instr(6'h00, 4'h0, 32'd7, 32'd0, 50, acked);
        expect_ack(acked);
        send_instr(6'h0E, 4'h7, 32'h40, 32'h0, 50, acked);
        expect_ack(acked);
        send_instr(6'h03, 4'h0, 32'h0, 32'hff, 50, acked);
        expect_ack(acked);
        send_instr(6'h0E, 4'h9, 32'h80, 32'h0, 50, acked);
        expect_ack(acked);
        send_instr(6'h13, 4'hA, 32'h0, 32'h0, 50, acked);
        expect_ack(acked);
        wait_drain();

        // Back-pressure fills the ALU and the queue, then in_ack stops
        stall = 1'b1;
        n_acked = 0;
        acked = 1'b1;
        while (acked && n_acked < 3 * FIFO_DEPTH) begin
            send_random(15, acked);
            if (acked) n_acked++;
        end
        check_val("accepted_while_stalled", n_acked, FIFO_DEPTH + 1);
        repeat (40) begin
            @(negedge iw_clk);
            check_val("in_ack", 32'(in_ack), 32'h0);
        end
        stall = 1'b0;
        n = 0;
        while (!in_ack && n < 100) begin
            @(negedge iw_clk);
            n++;
        end
        if (in_ack) begin
            release_req();
        end else begin
            n_other++;
            $display("Error: in_ack did not rise after out_ack was released");
        end
        wait_drain();

        $display("Errors: %0d mismatches, %0d other failures", n_fail, n_other);
        if (n_fail + n_other == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: source/ex_stage.sv
module ex_stage import ex_sizes_pkg::*, ex_isa_pkg::*; #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic   iw_clk,
    input  logic   iw_rst,
    input  logic   in_req,
    output logic   in_ack,
    input  opc_e   in_opc,
    input  cc_e    in_cc,
    input  data_t  in_pc,
    input  data_t  in_src,
    input  data_t  in_tgt,
    input  imm_t   in_imm,
    output logic   out_req,
    input  logic   out_ack,
    output data_t  out_result,
    output flags_t out_flags,
    output logic   out_branch_taken,
    output data_t  out_branch_pc
);

    ex_op_if q_in ();   // Issue to queue
    ex_op_if q_out ();  // Queue to ALU

    ex_issue u_issue (
        .iw_clk (iw_clk),
        .iw_rst (iw_rst),
        .in_req (in_req),
        .in_ack (in_ack),
        .in_opc (in_opc),
        .in_cc  (in_cc),
        .in_pc  (in_pc),
        .in_src (in_src),
        .in_tgt (in_tgt),
        .in_imm (in_imm),
        .q      (q_in.source)
    );

    ex_op_queue #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_queue (
        .iw_clk (iw_clk),
        .iw_rst (iw_rst),
        .wr     (q_in.sink),
        .rd     (q_out.source)
    );

    ex_alu u_alu (
        .iw_clk           (iw_clk),
        .iw_rst           (iw_rst),
        .q                (q_out.sink),
        .out_req          (out_req),
        .out_ack          (out_ack),
        .out_result       (out_result),
        .out_flags        (out_flags),
        .out_branch_taken (out_branch_taken),
        .out_branch_pc    (out_branch_pc)
    );

endmodule

// File: ex_alu/ex_alu.sv
module ex_alu import ex_sizes_pkg::*, ex_isa_pkg::*; (
    input  logic   iw_clk,
    input  logic   iw_rst,
    ex_op_if.sink  q,
    output logic   out_req,
    input  logic   out_ack,
    output data_t  out_result,
    output flags_t out_flags,
    output logic   out_branch_taken,
    output data_t  out_branch_pc
);

    data_t  a;
    data_t  b;
    data_t  sum;
    data_t  diff;
    data_t  res;
    flags_t fl_nxt;
    logic   add_ovf;
    logic   sub_ovf;
    logic   sh_big;
    logic   cc_true;
    logic   taken;
    logic   pop;

    assign a    = q.op.a;
    assign b    = q.op.b;
    assign sum  = a + b;
    assign diff = b - a;  // Subtraction keeps the b minus a operand order

    assign add_ovf = (a[DATA_W-1] == b[DATA_W-1]) && (sum[DATA_W-1] != a[DATA_W-1]);
    assign sub_ovf = (a[DATA_W-1] != b[DATA_W-1]) && (diff[DATA_W-1] != b[DATA_W-1]);
    assign sh_big  = |a[DATA_W-1:SHAMT_W];

    // ####################
    // Result and flags
    // ####################

    always_comb begin
        res    = '0;
        fl_nxt = out_flags;  // Flags not written by the op keep their value
        case (q.op.fn)
            FN_MOV: res = a;
            FN_ADD: begin
                res = sum;
                if (q.op.sgn) begin
                    fl_nxt.n = sum[DATA_W-1];
                    fl_nxt.v = add_ovf;
                end else begin
                    fl_nxt.c = (sum < a);
                end
            end
            FN_SUB: begin
                res = diff;
                if (q.op.sgn) begin
                    fl_nxt.n = diff[DATA_W-1];
                    fl_nxt.v = sub_ovf;
                end else begin
                    fl_nxt.c = (b < a);
                end
            end
            FN_AND: res = a & b;
            FN_OR:  res = a | b;
            FN_XOR: res = a ^ b;
            FN_SHL: res = sh_big ? '0 : b << a[SHAMT_W-1:0];
            FN_SHR: res = sh_big ? '0 : b >> a[SHAMT_W-1:0];
            FN_SAR: res = sh_big ? '0 : data_t'($signed(b) >>> a[SHAMT_W-1:0]);
            FN_CMP: begin
                fl_nxt.z = (a == b);
                if (q.op.sgn) begin
                    fl_nxt.n = diff[DATA_W-1];
                    fl_nxt.v = sub_ovf;
                end else begin
                    fl_nxt.c = (b < a);
                end
            end
            FN_BRANCH: res = '0;
            default: fl_nxt = '0;  // Illegal op clears every flag
        endcase
        if (q.op.fn inside {FN_MOV, FN_ADD, FN_SUB, FN_AND, FN_OR, FN_XOR,
                            FN_SHL, FN_SHR, FN_SAR}) begin
            fl_nxt.z = (res == '0);
        end
        if (q.op.fn inside {FN_SHL, FN_SHR, FN_SAR}) begin
            fl_nxt.v = sh_big;
        end
        if (q.op.fn == FN_SAR) begin
            fl_nxt.n = res[DATA_W-1];
        end
    end

    // ####################
    // Branch decision
    // ####################

    // Conditions look at the flags left by the previous op
    always_comb begin
        case (q.op.cc)
            CC_RA:   cc_true = 1'b1;
            CC_EQ:   cc_true = out_flags.z;
            CC_NE:   cc_true = !out_flags.z;
            CC_LT:   cc_true = out_flags.n ^ out_flags.v;
            CC_GT:   cc_true = !out_flags.z && !(out_flags.n ^ out_flags.v);
            CC_GE:   cc_true = !(out_flags.n ^ out_flags.v);
            CC_LE:   cc_true = out_flags.z || (out_flags.n ^ out_flags.v);
            CC_BT:   cc_true = out_flags.c;
            CC_AT:   cc_true = !out_flags.c && !out_flags.z;
            CC_BE:   cc_true = out_flags.c || out_flags.z;
            CC_AE:   cc_true = !out_flags.c;
            default: cc_true = 1'b0;
        endcase
    end

    assign taken = (q.op.fn == FN_BRANCH) && cc_true;

    // ####################
    // Four-phase output side
    // ####################

    assign q.ready = !out_req && !out_ack;  // Pop only once the previous ack has dropped
    assign pop     = q.valid && q.ready;

    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            out_req   <= 1'b0;
            out_flags <= '0;
        end else if (pop) begin
            out_req   <= 1'b1;
            out_flags <= fl_nxt;
        end else if (out_req && out_ack) begin
            out_req   <= 1'b0;
        end
    end

    always_ff @(posedge iw_clk) begin
        if (pop) begin
            out_result       <= res;
            out_branch_taken <= taken;
            out_branch_pc    <= taken ? q.op.pc + a : '0;
        end
    end

endmodule

// File: source/ex_issue.sv
module ex_issue import ex_sizes_pkg::*, ex_isa_pkg::*; (
    input  logic  iw_clk,
    input  logic  iw_rst,
    input  logic  in_req,
    output logic  in_ack,
    input  opc_e  in_opc,
    input  cc_e   in_cc,
    input  data_t in_pc,
    input  data_t in_src,
    input  data_t in_tgt,
    input  imm_t  in_imm,
    ex_op_if.source q
);

    ex_op_t dec;
    data_t  imm_zx;
    data_t  imm_sx;

    assign imm_zx = {{(DATA_W-IMM_W){1'b0}}, in_imm};
    assign imm_sx = {{(DATA_W-IMM_W){in_imm[IMM_W-1]}}, in_imm};

    // ####################
    // Decode
    // ####################

    always_comb begin
        dec     = '0;
        dec.fn  = FN_ILLEGAL;
        dec.cc  = in_cc;
        dec.pc  = in_pc;
        dec.a   = in_src;
        dec.b   = in_tgt;
        case (in_opc)
            OPC_MOVU:  dec.fn = FN_MOV;
            OPC_ADDU:  dec.fn = FN_ADD;
            OPC_SUBU:  dec.fn = FN_SUB;
            OPC_ANDU:  dec.fn = FN_AND;
            OPC_ORU:   dec.fn = FN_OR;
            OPC_XORU:  dec.fn = FN_XOR;
            OPC_SHLU:  dec.fn = FN_SHL;
            OPC_SHRU:  dec.fn = FN_SHR;
            OPC_CMPU:  dec.fn = FN_CMP;
            OPC_JCCU:  dec.fn = FN_BRANCH;
            OPC_ADDS:  {dec.fn, dec.sgn} = {FN_ADD, 1'b1};
            OPC_SUBS:  {dec.fn, dec.sgn} = {FN_SUB, 1'b1};
            OPC_SHRS:  {dec.fn, dec.sgn} = {FN_SAR, 1'b1};
            OPC_CMPS:  {dec.fn, dec.sgn} = {FN_CMP, 1'b1};
            OPC_MOVIU: {dec.fn, dec.a} = {FN_MOV, imm_zx};
            OPC_ADDIU: {dec.fn, dec.a} = {FN_ADD, imm_zx};
            OPC_ADDIS: {dec.fn, dec.sgn, dec.a} = {FN_ADD, 1'b1, imm_sx};
            OPC_BCCIS: {dec.fn, dec.a} = {FN_BRANCH, imm_sx};
            default:   dec.fn = FN_ILLEGAL;
        endcase
    end

    // ####################
    // Four-phase input side
    // ####################

    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            q.valid <= 1'b0;
            in_ack  <= 1'b0;
        end else if (!q.valid && !in_ack && in_req) begin
            q.valid <= 1'b1;  // Request seen, offer the decoded op to the queue
        end else if (q.valid && q.ready) begin
            q.valid <= 1'b0;
            in_ack  <= 1'b1;  // Acknowledge only once the op sits in the queue
        end else if (in_ack && !in_req) begin
            in_ack  <= 1'b0;
        end
    end

    always_ff @(posedge iw_clk) begin
        if (!q.valid && !in_ack && in_req) begin
            q.op <= dec;
        end
    end

endmodule

// File: source/ex_op_queue.sv
module ex_op_queue import ex_isa_pkg::*; #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic iw_clk,
    input  logic iw_rst,
    ex_op_if.sink   wr,
    ex_op_if.source rd
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);

    ex_op_t           mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             push;
    logic             pop;

    assign wr.ready = (count != FIFO_DEPTH[PTR_W:0]);
    assign rd.valid = (count != '0);
    assign rd.op    = mem[rd_ptr];

    assign push = wr.valid && wr.ready;
    assign pop  = rd.valid && rd.ready;

    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;  // Depth is a power of two so pointers wrap freely
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge iw_clk) begin
        if (push) begin
            mem[wr_ptr] <= wr.op;
        end
    end

endmodule

// File: common/ex_op_if.sv
interface ex_op_if import ex_isa_pkg::*; ();

    ex_op_t op;
    logic   valid;
    logic   ready;

    // A transfer takes place on an edge where valid and ready are both high
    modport source (
        output op,
        output valid,
        input  ready
    );

    modport sink (
        input  op,
        input  valid,
        output ready
    );

endinterface

// File: common/ex_isa_pkg.sv
package ex_isa_pkg;
    import ex_sizes_pkg::*;

    // ####################
    // Instruction set
    // ####################

    typedef enum logic [5:0] {
        OPC_MOVU  = 6'h00,
        OPC_ADDU  = 6'h01,
        OPC_SUBU  = 6'h02,
        OPC_ANDU  = 6'h03,
        OPC_ORU   = 6'h04,
        OPC_XORU  = 6'h05,
        OPC_SHLU  = 6'h06,
        OPC_SHRU  = 6'h07,
        OPC_CMPU  = 6'h09,
        OPC_ADDS  = 6'h0A,
        OPC_SUBS  = 6'h0B,
        OPC_SHRS  = 6'h0C,
        OPC_CMPS  = 6'h0D,
        OPC_JCCU  = 6'h0E,
        OPC_MOVIU = 6'h10,
        OPC_ADDIU = 6'h11,
        OPC_ADDIS = 6'h12,
        OPC_BCCIS = 6'h13
    } opc_e;

    typedef enum logic [3:0] {
        CC_RA = 4'h0,
        CC_EQ = 4'h1,
        CC_NE = 4'h2,
        CC_LT = 4'h3,
        CC_GT = 4'h4,
        CC_GE = 4'h5,
        CC_LE = 4'h6,
        CC_BT = 4'h7,
        CC_AT = 4'h8,
        CC_BE = 4'h9,
        CC_AE = 4'hA
    } cc_e;

    typedef struct packed {
        logic z;
        logic n;
        logic c;
        logic v;
    } flags_t;

    // ####################
    // Decoded operation
    // ####################

    typedef enum logic [3:0] {
        FN_MOV, FN_ADD, FN_SUB, FN_AND, FN_OR, FN_XOR,
        FN_SHL, FN_SHR, FN_SAR, FN_CMP, FN_BRANCH, FN_ILLEGAL
    } alu_fn_e;

    typedef struct packed {
        alu_fn_e fn;
        logic    sgn;  // Selects signed flag rules for add, sub and cmp
        cc_e     cc;
        data_t   pc;
        data_t   a;
        data_t   b;
    } ex_op_t;

endpackage

// File: common/ex_sizes_pkg.sv
package ex_sizes_pkg;

    // ####################
    // Datapath widths
    // ####################

    localparam int DATA_W  = 32;
    localparam int IMM_W   = 12;
    localparam int SHAMT_W = 5;  // Shift amounts at or above 2**SHAMT_W clear the result

    // ####################
    // Vector types
    // ####################

    typedef logic [DATA_W-1:0] data_t;
    typedef logic [IMM_W-1:0]  imm_t;

endpackage
